//--- flist.f
+incdir+.
safe_domain_pkg.sv
pad_sel_if.sv
pad_mux_decode.sv
pad_route.sv
clk_divider.sv
safe_domain.sv
tb_safe_domain.sv

//--- Bender.yml
package:
  name: safe_domain

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - safe_domain_pkg.sv
      - pad_sel_if.sv
      - pad_mux_decode.sv
      - pad_route.sv
      - clk_divider.sv
      - safe_domain.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_safe_domain.sv

//--- tb_safe_domain.sv
// safe domain testbench
// random pad routing against a reference model, directed whole-group codes,
// reset output timing and divided clock checks

`timescale 1ns/10ps

`include "safe_domain_defs.svh"

module tb_safe_domain
  import safe_domain_pkg::*;
();

  // ************************************************************
  // run length and limits
  // ************************************************************

  localparam int RESET_CYCLES      = 4;
  localparam int CLOCK_CYCLES      = 64;
  localparam int DIRECTED_PER_CODE = 4;
  localparam int RANDOM_CYCLES     = 300;
  // whole run with a 2x margin
  localparam int TIMEOUT_CYCLES    = 2 * (RESET_CYCLES + 1 + CLOCK_CYCLES
                                          + 4 * DIRECTED_PER_CODE + RANDOM_CYCLES);

  logic             ref_clk;
  logic             rst;
  logic             slow_clk;
  logic             efpga_clk;
  logic             rst_out;
  pad_mux_t         pad_mux;
  logic [`N_IO-1:0] io_out;
  logic [`N_IO-1:0] io_in;
  logic [`N_IO-1:0] io_oe;
  logic [`N_IO-1:0] perio_out;
  logic [`N_IO-1:0] perio_in;
  logic [`N_IO-1:0] perio_oe;
  logic [`N_IO-1:0] apbio_out;
  logic [`N_IO-1:0] apbio_in;
  logic [`N_IO-1:0] apbio_oe;
  logic [`N_IO-1:0] fpgaio_out;
  logic [`N_IO-1:0] fpgaio_in;
  logic [`N_IO-1:0] fpgaio_oe;

  logic [31:0] lcg_state = 32'd26170;
  int          checks = 0;
  int          errors = 0;
  int          cycle_count = 0;
  // ref clock edges since rst_o fell, -1 while in reset
  int          clk_phase = -1;

  safe_domain dut_i (
    .ref_clk_i    (ref_clk),
    .rst_i        (rst),
    .slow_clk_o   (slow_clk),
    .efpga_clk_o  (efpga_clk),
    .rst_o        (rst_out),
    .pad_mux_i    (pad_mux),
    .io_out_o     (io_out),
    .io_in_i      (io_in),
    .io_oe_o      (io_oe),
    .perio_out_i  (perio_out),
    .perio_in_o   (perio_in),
    .perio_oe_i   (perio_oe),
    .apbio_out_i  (apbio_out),
    .apbio_in_o   (apbio_in),
    .apbio_oe_i   (apbio_oe),
    .fpgaio_out_i (fpgaio_out),
    .fpgaio_in_o  (fpgaio_in),
    .fpgaio_oe_i  (fpgaio_oe)
  );

  // 10 ns reference clock
  initial begin
    ref_clk = 1'b0;
    forever #5 ref_clk = ~ref_clk;
  end

  // ************************************************************
  // random numbers and stimulus
  // ************************************************************

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // built from the upper lcg bits, the low ones repeat quickly
  function automatic logic [`N_IO-1:0] rand_vec();
    logic [`N_IO-1:0] v;
    logic [31:0]      r;
    v = '0;
    for (int i = 0; i < `N_IO; i += 16) begin
      r = lcg_next();
      v = (v << 16) | `N_IO'(r[31:16]);
    end
    return v;
  endfunction

  task automatic drive_data();
    perio_out  <= rand_vec();
    perio_oe   <= rand_vec();
    apbio_out  <= rand_vec();
    apbio_oe   <= rand_vec();
    fpgaio_out <= rand_vec();
    fpgaio_oe  <= rand_vec();
    io_in      <= rand_vec();
  endtask

  task automatic drive_random_codes();
    logic [`N_IO-1:0] lo;
    logic [`N_IO-1:0] hi;
    pad_mux_t         codes;
    lo = rand_vec();
    hi = rand_vec();
    for (int k = 0; k < `N_IO; k++) begin
      codes[k] = pad_mux_e'({hi[k], lo[k]});
    end
    pad_mux <= codes;
  endtask

  task automatic drive_all_codes(input pad_mux_e code);
    pad_mux_t codes;
    for (int k = 0; k < `N_IO; k++) begin
      codes[k] = code;
    end
    pad_mux <= codes;
  endtask

  // ************************************************************
  // checks and reference model
  // ************************************************************

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s expected %h actual %h at %0t", name, exp, act, $time);
    end
  endtask

  // owner of each pad takes the pad, every other group reads zero
  task automatic check_routing();
    logic [`N_IO-1:0] exp_out;
    logic [`N_IO-1:0] exp_oe;
    logic [`N_IO-1:0] exp_perio_in;
    logic [`N_IO-1:0] exp_apbio_in;
    logic [`N_IO-1:0] exp_fpgaio_in;
    exp_out       = '0;
    exp_oe        = '0;
    exp_perio_in  = '0;
    exp_apbio_in  = '0;
    exp_fpgaio_in = '0;
    for (int k = 0; k < `N_IO; k++) begin
      case (pad_mux[k])
        PAD_MUX_PERIO: begin
          exp_out[k]      = perio_out[k];
          exp_oe[k]       = perio_oe[k];
          exp_perio_in[k] = io_in[k];
        end
        PAD_MUX_APBIO: begin
          exp_out[k]      = apbio_out[k];
          exp_oe[k]       = apbio_oe[k];
          exp_apbio_in[k] = io_in[k];
        end
        PAD_MUX_FPGAIO: begin
          exp_out[k]       = fpgaio_out[k];
          exp_oe[k]        = fpgaio_oe[k];
          exp_fpgaio_in[k] = io_in[k];
        end
        // off pad keeps zeros everywhere
        default: ;
      endcase
    end
    compare_value("io_out_o", exp_out, io_out);
    compare_value("io_oe_o", exp_oe, io_oe);
    compare_value("perio_in_o", exp_perio_in, perio_in);
    compare_value("apbio_in_o", exp_apbio_in, apbio_in);
    compare_value("fpgaio_in_o", exp_fpgaio_in, fpgaio_in);
  endtask

  // with every pad on one code the owner passes through whole
  task automatic check_whole_group(input pad_mux_e code);
    logic [`N_IO-1:0] exp_out;
    logic [`N_IO-1:0] exp_oe;
    exp_out = '0;
    exp_oe  = '0;
    if (code == PAD_MUX_PERIO) begin
      exp_out = perio_out;
      exp_oe  = perio_oe;
    end else if (code == PAD_MUX_APBIO) begin
      exp_out = apbio_out;
      exp_oe  = apbio_oe;
    end else if (code == PAD_MUX_FPGAIO) begin
      exp_out = fpgaio_out;
      exp_oe  = fpgaio_oe;
    end
    compare_value("io_out_o", exp_out, io_out);
    compare_value("io_oe_o", exp_oe, io_oe);
    compare_value("perio_in_o", (code == PAD_MUX_PERIO) ? io_in : '0, perio_in);
    compare_value("apbio_in_o", (code == PAD_MUX_APBIO) ? io_in : '0, apbio_in);
    compare_value("fpgaio_in_o", (code == PAD_MUX_FPGAIO) ? io_in : '0, fpgaio_in);
  endtask

  // divide by DIV: low for DIV/2 edges after reset, then toggles every DIV/2
  task automatic check_clocks(input int phase);
    if (phase < 0) begin
      compare_value("slow_clk_o", 0, slow_clk);
      compare_value("efpga_clk_o", 0, efpga_clk);
    end else begin
      compare_value("slow_clk_o", (phase / (`SLOW_CLK_DIV / 2)) % 2, slow_clk);
      compare_value("efpga_clk_o", (phase / (`EFPGA_CLK_DIV / 2)) % 2, efpga_clk);
    end
  endtask

  // sample mid cycle, once everything driven on the rising edge has settled
  task automatic finish_cycle();
    @(negedge ref_clk);
    compare_value("rst_o", 0, rst_out);
    check_routing();
    check_clocks(clk_phase);
    clk_phase++;
  endtask

  // ************************************************************
  // test sequence
  // ************************************************************

  initial begin
    rst        = 1'b1;
    perio_out  = '0;
    perio_oe   = '0;
    apbio_out  = '0;
    apbio_oe   = '0;
    fpgaio_out = '0;
    fpgaio_oe  = '0;
    io_in      = '0;
    for (int k = 0; k < `N_IO; k++) begin
      pad_mux[k] = PAD_MUX_PERIO;
    end

    // reset, released on the last of the four edges
    for (int c = 1; c <= RESET_CYCLES; c++) begin
      @(posedge ref_clk);
      if (c == RESET_CYCLES) begin
        rst <= 1'b0;
      end
      @(negedge ref_clk);
      compare_value("rst_o", 1, rst_out);
      check_routing();
      // dividers see the registered reset one edge late
      if (c > 1) begin
        check_clocks(-1);
      end
    end

    // first edge with rst_o low is phase 0
    clk_phase = 0;
    for (int i = 0; i < CLOCK_CYCLES; i++) begin
      @(posedge ref_clk);
      finish_cycle();
    end

    // every pad on one code, all four codes in turn
    for (int c = 0; c < 4; c++) begin
      for (int i = 0; i < DIRECTED_PER_CODE; i++) begin
        @(posedge ref_clk);
        drive_data();
        drive_all_codes(pad_mux_e'(c));
        finish_cycle();
        check_whole_group(pad_mux_e'(c));
      end
    end

    // random codes and data
    for (int i = 0; i < RANDOM_CYCLES; i++) begin
      @(posedge ref_clk);
      drive_data();
      drive_random_codes();
      finish_cycle();
    end

    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // run limit
  always @(posedge ref_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("tests failed");
      $finish;
    end
  end

endmodule

//--- safe_domain.sv
// always-on safe domain
// pad multiplexing between perio, apbio and fpgaio groups,
// slow and efpga clock generation and the chip reset register

`timescale 1ns/10ps

`include "safe_domain_defs.svh"

module safe_domain
  import safe_domain_pkg::*;
(
  input  logic             ref_clk_i,
  input  logic             rst_i,
  output logic             slow_clk_o,
  output logic             efpga_clk_o,
  output logic             rst_o,

  // pad control register
  input  pad_mux_t         pad_mux_i,

  // pads
  output logic [`N_IO-1:0] io_out_o,
  input  logic [`N_IO-1:0] io_in_i,
  output logic [`N_IO-1:0] io_oe_o,

  // peripheral i/os
  input  logic [`N_IO-1:0] perio_out_i,
  output logic [`N_IO-1:0] perio_in_o,
  input  logic [`N_IO-1:0] perio_oe_i,

  // bus-mapped i/os
  input  logic [`N_IO-1:0] apbio_out_i,
  output logic [`N_IO-1:0] apbio_in_o,
  input  logic [`N_IO-1:0] apbio_oe_i,

  // fpga i/os
  input  logic [`N_IO-1:0] fpgaio_out_i,
  output logic [`N_IO-1:0] fpgaio_in_o,
  input  logic [`N_IO-1:0] fpgaio_oe_i
);

  // ************************************************************
  // pad multiplexing
  // ************************************************************

  // decoded owner selects, valid whenever the codes are
  pad_sel_if sel_if ();

  pad_mux_decode i_pad_mux_decode (
    .pad_mux_i (pad_mux_i),
    .sel       (sel_if.producer)
  );

  // fully combinational, same cycle as the code change
  pad_route i_pad_route (
    .sel          (sel_if.consumer),
    .io_in_i      (io_in_i),
    .io_out_o     (io_out_o),
    .io_oe_o      (io_oe_o),
    .perio_out_i  (perio_out_i),
    .perio_oe_i   (perio_oe_i),
    .perio_in_o   (perio_in_o),
    .apbio_out_i  (apbio_out_i),
    .apbio_oe_i   (apbio_oe_i),
    .apbio_in_o   (apbio_in_o),
    .fpgaio_out_i (fpgaio_out_i),
    .fpgaio_oe_i  (fpgaio_oe_i),
    .fpgaio_in_o  (fpgaio_in_o)
  );

  // ************************************************************
  // reset and clocks
  // ************************************************************

  // chip reset, rst_i one ref clock later
  always_ff @(posedge ref_clk_i) begin
    if (rst_i) begin
      rst_o <= 1'b1;
    end else begin
      rst_o <= 1'b0;
    end
  end

  // dividers run off the registered reset so they start in step with the chip
  clk_divider #(
    .DIV (`SLOW_CLK_DIV)
  ) i_slow_clk_div (
    .ref_clk_i (ref_clk_i),
    .rst_i     (rst_o),
    .clk_o     (slow_clk_o)
  );

  clk_divider #(
    .DIV (`EFPGA_CLK_DIV)
  ) i_efpga_clk_div (
    .ref_clk_i (ref_clk_i),
    .rst_i     (rst_o),
    .clk_o     (efpga_clk_o)
  );

endmodule

//--- clk_divider.sv
// even integer clock divider
// divides the reference clock by DIV with a 50 % duty cycle

`timescale 1ns/10ps

module clk_divider #(
  // even, at least 2
  parameter int unsigned DIV = 2
) (
  input  logic ref_clk_i,
  input  logic rst_i,
  output logic clk_o
);

  // cycles per half period
  localparam int unsigned HALF = DIV / 2;
  // keep at least one counter bit when DIV is 2
  localparam int unsigned CNT_W = (HALF > 1) ? $clog2(HALF) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(HALF - 1);

  logic [CNT_W-1:0] cnt_q;
  logic             clk_q;
  logic             wrap;

  // end of a half period
  assign wrap = (cnt_q == CNT_LAST);

  // ************************************************************
  // half period counter and output toggle
  // ************************************************************

  always_ff @(posedge ref_clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
      clk_q <= 1'b0;
    end else begin
      if (wrap) begin
        cnt_q <= '0;
        // first toggle HALF cycles after reset release, rising
        clk_q <= ~clk_q;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // straight from the flop, no glitches
  assign clk_o = clk_q;

endmodule

//--- pad_route.sv
// pad router
// puts the owning group's out/oe on each pad and returns pad inputs to the owner only

`timescale 1ns/10ps

`include "safe_domain_defs.svh"

module pad_route (
  // owner selects from the decoder
  pad_sel_if.consumer      sel,

  // pad side
  input  logic [`N_IO-1:0] io_in_i,
  output logic [`N_IO-1:0] io_out_o,
  output logic [`N_IO-1:0] io_oe_o,

  // peripheral group
  input  logic [`N_IO-1:0] perio_out_i,
  input  logic [`N_IO-1:0] perio_oe_i,
  output logic [`N_IO-1:0] perio_in_o,

  // bus-mapped group
  input  logic [`N_IO-1:0] apbio_out_i,
  input  logic [`N_IO-1:0] apbio_oe_i,
  output logic [`N_IO-1:0] apbio_in_o,

  // fpga group
  input  logic [`N_IO-1:0] fpgaio_out_i,
  input  logic [`N_IO-1:0] fpgaio_oe_i,
  output logic [`N_IO-1:0] fpgaio_in_o
);

  // ************************************************************
  // outbound: group -> pad
  // ************************************************************

  always_comb begin
    io_out_o = '0;
    io_oe_o  = '0;
    for (int k = 0; k < `N_IO; k++) begin
      // select order is {off, fpgaio, apbio, perio}
      case ({sel.sel_off[k], sel.sel_fpgaio[k], sel.sel_apbio[k], sel.sel_perio[k]})
        4'b0001: begin
          io_out_o[k] = perio_out_i[k];
          io_oe_o[k]  = perio_oe_i[k];
        end
        4'b0010: begin
          io_out_o[k] = apbio_out_i[k];
          io_oe_o[k]  = apbio_oe_i[k];
        end
        4'b0100: begin
          io_out_o[k] = fpgaio_out_i[k];
          io_oe_o[k]  = fpgaio_oe_i[k];
        end
        // off pad, out low and not driven
        default: begin
          io_out_o[k] = 1'b0;
          io_oe_o[k]  = 1'b0;
        end
      endcase
    end
  end

  // ************************************************************
  // inbound: pad -> owning group
  // ************************************************************

  // groups that do not own a pad read zero on that bit
  assign perio_in_o  = io_in_i & sel.sel_perio;
  assign apbio_in_o  = io_in_i & sel.sel_apbio;
  assign fpgaio_in_o = io_in_i & sel.sel_fpgaio;

endmodule

//--- pad_mux_decode.sv
// pad mux code decoder
// turns each pad's 2-bit owner code into four one-hot select bits

`timescale 1ns/10ps

`include "safe_domain_defs.svh"

module pad_mux_decode
  import safe_domain_pkg::*;
(
  // codes from the pad control register
  input  pad_mux_t  pad_mux_i,
  // one-hot owner selects
  pad_sel_if.producer sel
);

  // local copies of the select vectors
  logic [`N_IO-1:0] dec_perio;
  logic [`N_IO-1:0] dec_apbio;
  logic [`N_IO-1:0] dec_fpgaio;
  logic [`N_IO-1:0] dec_off;

  // ************************************************************
  // per pad decode
  // ************************************************************

  always_comb begin
    dec_perio  = '0;
    dec_apbio  = '0;
    dec_fpgaio = '0;
    dec_off    = '0;
    for (int k = 0; k < `N_IO; k++) begin
      // two bits, four codes, so the case is full
      case (pad_mux_i[k])
        PAD_MUX_PERIO:  dec_perio[k]  = 1'b1;
        PAD_MUX_APBIO:  dec_apbio[k]  = 1'b1;
        PAD_MUX_FPGAIO: dec_fpgaio[k] = 1'b1;
        PAD_MUX_OFF:    dec_off[k]    = 1'b1;
      endcase
    end
  end

  // to the router
  assign sel.sel_perio  = dec_perio;
  assign sel.sel_apbio  = dec_apbio;
  assign sel.sel_fpgaio = dec_fpgaio;
  assign sel.sel_off    = dec_off;

endmodule

//--- pad_sel_if.sv
// pad select bundle
// one-hot owner selects per pad, from the code decoder to the pad router

`timescale 1ns/10ps

`include "safe_domain_defs.svh"

interface pad_sel_if;

  // bit k of each vector belongs to pad k
  // exactly one of the four is set per pad
  logic [`N_IO-1:0] sel_perio;
  logic [`N_IO-1:0] sel_apbio;
  logic [`N_IO-1:0] sel_fpgaio;
  logic [`N_IO-1:0] sel_off;

  // decoder side
  modport producer (
    output sel_perio,
    output sel_apbio,
    output sel_fpgaio,
    output sel_off
  );

  // router side
  modport consumer (
    input sel_perio,
    input sel_apbio,
    input sel_fpgaio,
    input sel_off
  );

endinterface

//--- safe_domain_pkg.sv
// safe domain types
// pad mux code encoding and the per-pad code array from the pad control register

`include "safe_domain_defs.svh"

package safe_domain_pkg;

  // ************************************************************
  // pad mux codes
  // ************************************************************

  // owner of a pad, one code per pad
  typedef enum logic [`NBIT_PADMUX-1:0] {
    // peripheral i/os
    PAD_MUX_PERIO  = 2'd0,
    // bus-mapped i/os
    PAD_MUX_APBIO  = 2'd1,
    // fpga i/os
    PAD_MUX_FPGAIO = 2'd2,
    // pad not driven, input dropped
    PAD_MUX_OFF    = 2'd3
  } pad_mux_e;

  // full pad control word, entry k belongs to pad k
  // 16 pads x 2 bits gives 32 bits
  typedef pad_mux_e [`N_IO-1:0] pad_mux_t;

endpackage

//--- safe_domain_defs.svh
// safe domain build constants
// pad count, mux code width and the ratios of the two divided clocks

`ifndef SAFE_DOMAIN_DEFS_SVH
`define SAFE_DOMAIN_DEFS_SVH

// ************************************************************
// pad geometry
// ************************************************************

// number of pads, also the width of every source group
`define N_IO 16

// bits of mux code per pad
// two bits give perio, apbio, fpgaio and off
`define NBIT_PADMUX 2

// ************************************************************
// clock division
// ************************************************************

// slow clock ratio, must be even
`define SLOW_CLK_DIV 8

// efpga clock ratio, must be even
`define EFPGA_CLK_DIV 4

`endif
